// File: design/mac_settings.svh
//~~~~~~~~~~~~~~~~~~~~
// widths and limits of the 32-bit multiply-accumulate unit
// include this wherever a width or the select limit is needed
//~~~~~~~~~~~~~~~~~~~~
`ifndef MAC_SETTINGS_SVH
`define MAC_SETTINGS_SVH

// both multiplier inputs carry operands of this width
`define MAC_OPER_W 32

// guard bits on top of each operand take one quarter of its width
`define MAC_PAD_W (`MAC_OPER_W / 4)

// an operand grows to this width before it enters the multiplier
`define MAC_EXT_W (`MAC_OPER_W + `MAC_PAD_W)

// the accumulator holds a full product of two extended operands
`define MAC_ACC_W (2 * `MAC_EXT_W)

// the output select code is six bits wide
`define MAC_SEL_W 6
// select codes above this one fall back to the lowest window
`define MAC_SEL_MAX 48

`endif

// File: design/mac_arith_pkg.sv
//~~~~~~~~~~~~~~~~~~~~
// data types of the MAC datapath
// import it into any block that handles operands or accumulator words
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mac_settings.svh"

package mac_arith_pkg;

  // raw data or coefficient word as it arrives at the top level
  typedef logic [`MAC_OPER_W-1:0] oper_t;

  // operand with its guard bits in place
  // the guard bits carry the sign in two's-complement mode and zeros otherwise
  typedef logic [`MAC_EXT_W-1:0] ext_oper_t;

  // accumulator register, and also the addend fed back into the adder
  typedef logic [`MAC_ACC_W-1:0] acc_t;

  // window cut from the accumulator and driven out of the unit
  typedef logic [`MAC_OPER_W-1:0] mac_word_t;

endpackage

`default_nettype wire

// File: design/mac_ctrl_pkg.sv
//~~~~~~~~~~~~~~~~~~~~
// control types of the MAC, the select code and the arithmetic mode
// import it where the select or the tc input is decoded
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mac_settings.svh"

package mac_ctrl_pkg;

  // one code picks both the output window and the rounding bit
  typedef logic [`MAC_SEL_W-1:0] out_sel_t;

  // the tc input is cast to this enum inside each block
  typedef enum logic {
    mode_unsigned  = 1'b0,
    mode_twos_comp = 1'b1
  } mac_mode_e;

endpackage

`default_nettype wire

// File: design/mac_unit.sv
//~~~~~~~~~~~~~~~~~~~~
// multiply-add core with the 80-bit accumulator register
// extends the operands, picks the fed back addend and loads the sum
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mac_settings.svh"

module mac_unit
  import mac_arith_pkg::*, mac_ctrl_pkg::*;
(
  input  logic     MAC_ACC_CLK,
  input  logic     acc_ff_rstn,
  input  logic     clk_en,
  input  oper_t    oper_data,
  input  oper_t    coef_data,
  input  logic     tc,
  input  logic     acc_clear,
  input  logic     acc_rnd,
  input  out_sel_t out_sel,
  output acc_t     acc_q
);

  mac_mode_e mode;
  logic      oper_sign;
  logic      coef_sign;
  ext_oper_t oper_ext;
  ext_oper_t coef_ext;
  logic signed [`MAC_ACC_W-1:0] oper_wide;
  logic signed [`MAC_ACC_W-1:0] coef_wide;
  acc_t      product;
  acc_t      rnd_value;
  acc_t      feedback;
  acc_t      acc_sum;

  // tc is a plain level at the port, the enum gives it a name here
  assign mode = mac_mode_e'(tc);

  // in unsigned mode the guard bits stay zero
  // so the extended operand is never negative
  assign oper_sign = (mode == mode_twos_comp) & oper_data[`MAC_OPER_W-1];
  assign coef_sign = (mode == mode_twos_comp) & coef_data[`MAC_OPER_W-1];

  assign oper_ext = {{`MAC_PAD_W{oper_sign}}, oper_data};
  assign coef_ext = {{`MAC_PAD_W{coef_sign}}, coef_data};

  // widen once more to the accumulator width by the top guard bit
  // this makes the product come out modulo 2^80 in both modes
  assign oper_wide = {{`MAC_EXT_W{oper_ext[`MAC_EXT_W-1]}}, oper_ext};
  assign coef_wide = {{`MAC_EXT_W{coef_ext[`MAC_EXT_W-1]}}, coef_ext};

  // only the lower half of the wide product is kept
  // the upper half is nothing but sign copies
  assign product = oper_wide * coef_wide;

  // rounding adds one half of the lsb of the window that the select picks,
  // that is a single bit just below the window
  always_comb begin
    rnd_value = '0;
    if ((out_sel != '0) && (out_sel <= out_sel_t'(`MAC_SEL_MAX))) begin
      rnd_value[out_sel - out_sel_t'(1)] = 1'b1;
    end
  end

  // clear wins over round, and round wins over the normal feedback
  // the current select is used here, not the delayed one at the output
  always_comb begin
    if (acc_clear) begin
      feedback = '0;
    end else if (acc_rnd) begin
      feedback = rnd_value;
    end else begin
      feedback = acc_q;
    end
  end

  // carries out of bit 79 are dropped
  assign acc_sum = product + feedback;

  // the accumulator only moves when the clock enable is high
  always_ff @(posedge MAC_ACC_CLK or negedge acc_ff_rstn) begin
    if (!acc_ff_rstn) begin
      acc_q <= '0;
    end else if (clk_en) begin
      acc_q <= acc_sum;
    end
  end

endmodule

`default_nettype wire

// File: design/acc_out_stage.sv
//~~~~~~~~~~~~~~~~~~~~
// output stage of the MAC
// cuts a 32-bit window from the accumulator and clamps it on overflow
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mac_settings.svh"

module acc_out_stage
  import mac_arith_pkg::*, mac_ctrl_pkg::*;
(
  input  logic      MAC_ACC_CLK,
  input  logic      acc_ff_rstn,
  input  acc_t      acc_q,
  input  out_sel_t  out_sel,
  input  logic      tc,
  input  logic      acc_sat,
  output mac_word_t mac_out
);

  mac_mode_e mode;
  out_sel_t  sel_d;
  logic      win_in_range;
  out_sel_t  win_shift;
  acc_t      acc_shifted;
  mac_word_t window;
  out_sel_t  sat_shift;
  logic [`MAC_SEL_W:0] sat_base;
  acc_t      hi_mask;
  logic      hi_ones;
  logic      hi_zeros;
  logic      un_zeros;
  logic      not_sat;
  mac_word_t sat_limit;

  // the output stage reads tc and acc_sat without any delay
  assign mode = mac_mode_e'(tc);

  // the select is registered once
  // it then lines up with the accumulator that the same edge loaded
  always_ff @(posedge MAC_ACC_CLK or negedge acc_ff_rstn) begin
    if (!acc_ff_rstn) begin
      sel_d <= '0;
    end else begin
      sel_d <= out_sel;
    end
  end

  // codes 49 to 63 have no window of their own and show bits 31 to 0
  assign win_in_range = (sel_d <= out_sel_t'(`MAC_SEL_MAX));
  assign win_shift    = win_in_range ? sel_d : '0;

  // a right shift brings the window down to bit 0
  assign acc_shifted = acc_q >> win_shift;
  assign window      = acc_shifted[`MAC_OPER_W-1:0];

  // the overflow check covers one code less than the window does
  // code 48 is therefore tested as if it were code 0
  assign sat_shift = (sel_d < out_sel_t'(`MAC_SEL_MAX)) ? sel_d : '0;

  // lowest bit of the range that must hold copies of the window sign,
  // which is the top bit of the window
  assign sat_base = {1'b0, sat_shift} + (`MAC_SEL_W+1)'(`MAC_OPER_W - 1);

  // ones from sat_base up to bit 79
  assign hi_mask = {`MAC_ACC_W{1'b1}} << sat_base;

  // a window that fits as a signed value has all ones or all zeros above it
  assign hi_ones  = ((acc_q & hi_mask) == hi_mask);
  assign hi_zeros = ((acc_q & hi_mask) == '0);

  // an unsigned window may use its top bit, so the check starts one bit higher
  assign un_zeros = ((acc_q & (hi_mask << 1)) == '0);

  // the first two cases hold in either mode, the third only when unsigned
  assign not_sat = hi_ones | hi_zeros | ((mode == mode_unsigned) & un_zeros);

  // signed limits follow bit 79
  // negative values clamp to 0x80000000 and positive values to 0x7fffffff
  always_comb begin
    if (mode == mode_unsigned) begin
      sat_limit = '1;
    end else begin
      sat_limit = {acc_q[`MAC_ACC_W-1], {(`MAC_OPER_W-1){~acc_q[`MAC_ACC_W-1]}}};
    end
  end

  // clamping only happens with saturation enabled
  // otherwise the window goes out as it is, wrapped if it overflows
  always_comb begin
    if (acc_sat && !not_sat) begin
      mac_out = sat_limit;
    end else begin
      mac_out = window;
    end
  end

endmodule

`default_nettype wire

// File: design/mac_32bit.sv
//~~~~~~~~~~~~~~~~~~~~
// top level of the 32-bit multiply-accumulate unit
// every input is a level sampled on the rising edge of MAC_ACC_CLK
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mac_settings.svh"

module mac_32bit
  import mac_arith_pkg::*, mac_ctrl_pkg::*;
(
  input  logic      MAC_ACC_CLK,
  input  logic      acc_ff_rstn,
  input  logic      clk_en,
  input  oper_t     oper_data,
  input  oper_t     coef_data,
  input  logic      acc_rnd,
  input  logic      acc_clear,
  input  logic      acc_sat,
  input  out_sel_t  out_sel,
  input  logic      tc,
  output mac_word_t mac_out
);

  // accumulator value passed from the core to the output stage
  acc_t acc_q;

  // the core sees the undelayed select, since it only needs the rounding bit
  mac_unit u_mac_unit (
    .MAC_ACC_CLK (MAC_ACC_CLK),
    .acc_ff_rstn (acc_ff_rstn),
    .clk_en      (clk_en),
    .oper_data   (oper_data),
    .coef_data   (coef_data),
    .tc          (tc),
    .acc_clear   (acc_clear),
    .acc_rnd     (acc_rnd),
    .out_sel     (out_sel),
    .acc_q       (acc_q)
  );

  // the output stage delays the select by one cycle on its own
  // tc and acc_sat reach it in the same cycle as they change
  acc_out_stage u_acc_out_stage (
    .MAC_ACC_CLK (MAC_ACC_CLK),
    .acc_ff_rstn (acc_ff_rstn),
    .acc_q       (acc_q),
    .out_sel     (out_sel),
    .tc          (tc),
    .acc_sat     (acc_sat),
    .mac_out     (mac_out)
  );

endmodule

`default_nettype wire

// File: verif/mac_checker.sv
//~~~~~~~~~~~~~~~~~~~~
// reference model and comparator for the MAC testbench
// samples the DUT inputs on each rising edge, checks mac_out on the falling edge
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mac_settings.svh"

module mac_checker
  import mac_arith_pkg::*, mac_ctrl_pkg::*;
(
  input  logic      MAC_ACC_CLK,
  input  logic      acc_ff_rstn,
  input  logic      clk_en,
  input  oper_t     oper_data,
  input  oper_t     coef_data,
  input  logic      acc_rnd,
  input  logic      acc_clear,
  input  logic      acc_sat,
  input  out_sel_t  out_sel,
  input  logic      tc,
  input  mac_word_t mac_out,
  output int        err_total,
  output int        sat_hits
);

  // model state, the accumulator and the select as seen one edge late
  acc_t      model_acc = '0;
  out_sel_t  model_sel = '0;
  mac_word_t expected;
  string     test_name = "none";
  int        checks = 0;
  int        errs = 0;
  int        sats = 0;
  int        mark_checks = 0;
  int        mark_errs = 0;
  int        tests_run = 0;
  int        tests_failed = 0;

  assign err_total = errs;
  assign sat_hits  = sats;

  // an operand grows straight to 80 bits, by its sign only in two's-complement mode
  function automatic acc_t widen(input oper_t v, input mac_mode_e mode);
    logic fill;
    fill = (mode == mode_twos_comp) & v[`MAC_OPER_W-1];
    return {{(`MAC_ACC_W - `MAC_OPER_W){fill}}, v};
  endfunction

  // clear beats round, round beats the held value, and the sum wraps at 2^80
  function automatic acc_t next_acc(input acc_t acc, input oper_t a, input oper_t b,
                                    input mac_mode_e mode, input logic clr,
                                    input logic rnd, input out_sel_t sel);
    acc_t addend;
    int   pos;
    pos = int'(sel);
    if (clr) begin
      addend = '0;
    end else if (rnd) begin
      addend = '0;
      if (pos >= 1 && pos <= `MAC_SEL_MAX) begin
        addend = acc_t'(1) << (pos - 1);
      end
    end else begin
      addend = acc;
    end
    return widen(a, mode) * widen(b, mode) + addend;
  endfunction

  // the field from bit 31+s to the top must be a plain sign copy,
  // or in unsigned mode zero from bit 32+s up
  function automatic logic saturated(input acc_t acc, input out_sel_t sel,
                                     input mac_mode_e mode);
    int   s;
    acc_t top;
    acc_t all_ones;
    s = (int'(sel) < `MAC_SEL_MAX) ? int'(sel) : 0;
    top = acc >> (`MAC_OPER_W - 1 + s);
    all_ones = (acc_t'(1) << (`MAC_ACC_W - (`MAC_OPER_W - 1) - s)) - acc_t'(1);
    if (top == all_ones || top == '0) begin
      return 1'b0;
    end
    if (mode == mode_unsigned && (acc >> (`MAC_OPER_W + s)) == '0) begin
      return 1'b0;
    end
    return 1'b1;
  endfunction

  // limit values when clamping, otherwise the 32-bit window at the delayed select
  function automatic mac_word_t expect_out(input acc_t acc, input out_sel_t sel,
                                           input mac_mode_e mode, input logic sat);
    int   w;
    acc_t shifted;
    if (sat && saturated(acc, sel, mode)) begin
      if (mode == mode_unsigned) begin
        return 32'hffff_ffff;
      end
      return acc[`MAC_ACC_W-1] ? 32'h8000_0000 : 32'h7fff_ffff;
    end
    w = (int'(sel) <= `MAC_SEL_MAX) ? int'(sel) : 0;
    shifted = acc >> w;
    return shifted[`MAC_OPER_W-1:0];
  endfunction

  // the model takes the inputs at the same edge as the DUT registers
  always @(posedge MAC_ACC_CLK or negedge acc_ff_rstn) begin
    if (!acc_ff_rstn) begin
      model_acc <= '0;
      model_sel <= '0;
    end else begin
      if (clk_en) begin
        model_acc <= next_acc(model_acc, oper_data, coef_data, mac_mode_e'(tc),
                              acc_clear, acc_rnd, out_sel);
      end
      model_sel <= out_sel;
    end
  end

  // halfway through the cycle every output has settled
  always @(negedge MAC_ACC_CLK) begin
    expected = expect_out(model_acc, model_sel, mac_mode_e'(tc), acc_sat);
    checks = checks + 1;
    if (acc_sat && saturated(model_acc, model_sel, mac_mode_e'(tc))) begin
      sats = sats + 1;
    end
    if (mac_out !== expected) begin
      errs = errs + 1;
      $display("MISMATCH %s: expected 0x%08h actual 0x%08h at time %0t",
               test_name, expected, mac_out, $time);
    end
  end

  task automatic open_test(input string name);
    test_name   = name;
    mark_checks = checks;
    mark_errs   = errs;
  endtask

  task automatic close_test();
    int n_checks;
    int n_errs;
    n_checks  = checks - mark_checks;
    n_errs    = errs - mark_errs;
    tests_run = tests_run + 1;
    if (n_errs == 0) begin
      $display("test %s passed, %0d checks", test_name, n_checks);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %s failed, %0d of %0d checks wrong", test_name, n_errs, n_checks);
    end
  endtask

  task automatic print_counts();
    $display("tests %0d, failing tests %0d, checks %0d, mismatches %0d, clamped cycles %0d",
             tests_run, tests_failed, checks, errs, sats);
  endtask

endmodule

`default_nettype wire

// File: verif/tb_mac_32bit.sv
//~~~~~~~~~~~~~~~~~~~~
// testbench top for the 32-bit MAC
// drives seeded random stimulus in phases, mac_checker compares the output
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mac_settings.svh"

module tb_mac_32bit
  import mac_arith_pkg::*, mac_ctrl_pkg::*;
();

  // the clock starts low with no edge at time zero
  logic        MAC_ACC_CLK = 1'b0;
  logic        acc_ff_rstn;
  logic        clk_en;
  oper_t       oper_data;
  oper_t       coef_data;
  logic        acc_rnd;
  logic        acc_clear;
  logic        acc_sat;
  out_sel_t    out_sel;
  logic        tc;
  mac_word_t   mac_out;
  int          err_total;
  int          sat_hits;
  logic        timed_out;

  mac_32bit dut (
    .MAC_ACC_CLK (MAC_ACC_CLK),
    .acc_ff_rstn (acc_ff_rstn),
    .clk_en      (clk_en),
    .oper_data   (oper_data),
    .coef_data   (coef_data),
    .acc_rnd     (acc_rnd),
    .acc_clear   (acc_clear),
    .acc_sat     (acc_sat),
    .out_sel     (out_sel),
    .tc          (tc),
    .mac_out     (mac_out)
  );

  mac_checker chk (
    .MAC_ACC_CLK (MAC_ACC_CLK),
    .acc_ff_rstn (acc_ff_rstn),
    .clk_en      (clk_en),
    .oper_data   (oper_data),
    .coef_data   (coef_data),
    .acc_rnd     (acc_rnd),
    .acc_clear   (acc_clear),
    .acc_sat     (acc_sat),
    .out_sel     (out_sel),
    .tc          (tc),
    .mac_out     (mac_out),
    .err_total   (err_total),
    .sat_hits    (sat_hits)
  );

  // period of 4, first rising edge at time 2
  initial begin
    forever begin
      #2 MAC_ACC_CLK = ~MAC_ACC_CLK;
    end
  end

  function automatic logic coin();
    return 1'($urandom);
  endfunction

  // code 48 comes up often, since its overflow test runs at shift 0
  function automatic out_sel_t sat_sel();
    if (($urandom % 4) == 0) begin
      return out_sel_t'(`MAC_SEL_MAX);
    end
    return out_sel_t'($urandom);
  endfunction

  // top bit forced high half the time, so most operands are negative
  function automatic oper_t signed_oper();
    oper_t v;
    v = oper_t'($urandom);
    if (coin()) begin
      v[`MAC_OPER_W-1] = 1'b1;
    end
    return v;
  endfunction

  // one set of input levels, applied just after a rising edge
  task automatic drive(input logic en, input logic clr, input logic rnd, input logic sat,
                       input logic mode, input out_sel_t sel, input oper_t a, input oper_t b);
    @(posedge MAC_ACC_CLK);
    clk_en    <= en;
    acc_clear <= clr;
    acc_rnd   <= rnd;
    acc_sat   <= sat;
    tc        <= mode;
    out_sel   <= sel;
    oper_data <= a;
    coef_data <= b;
  endtask

  // lets the last inputs reach a compare before the test is closed
  task automatic end_phase();
    @(posedge MAC_ACC_CLK);
    @(negedge MAC_ACC_CLK);
    @(posedge MAC_ACC_CLK);
    chk.close_test();
  endtask

  // clear, then a few small products that stay inside the window
  task automatic fill_small(input logic mode);
    oper_t a;
    drive(1'b1, 1'b1, 1'b0, 1'b1, mode, out_sel_t'($urandom), '0, '0);
    repeat (8) begin
      a = oper_t'($urandom % 65536);
      if (mode && coin()) begin
        a = -a;
      end
      drive(1'b1, 1'b0, 1'b0, 1'b1, mode, sat_sel(), a, oper_t'($urandom % 65536));
    end
  endtask

  // large products until the checker has seen eight clamped cycles
  task automatic push_until_sat(input logic mode, input logic neg);
    int    start;
    int    cycles;
    oper_t a;
    oper_t b;
    start  = sat_hits;
    cycles = 0;
    while ((sat_hits - start) < 8 && cycles < 200) begin
      a = {2'b01, 30'($urandom)};
      b = {2'b01, 30'($urandom)};
      if (neg) begin
        a = {2'b10, 30'($urandom)};
      end
      drive(1'b1, 1'b0, 1'b0, 1'b1, mode, sat_sel(), a, b);
      cycles = cycles + 1;
    end
    if ((sat_hits - start) < 8) begin
      $display("timeout: the output never clamped within 200 cycles in mode %0d", mode);
      timed_out = 1'b1;
    end
  endtask

  initial begin
    void'($urandom(32'h40e136a1));
    timed_out = 1'b0;
    acc_ff_rstn <= 1'b0;
    clk_en      <= 1'b0;
    oper_data   <= '0;
    coef_data   <= '0;
    acc_rnd     <= 1'b0;
    acc_clear   <= 1'b0;
    acc_sat     <= 1'b0;
    out_sel     <= '0;
    tc          <= 1'b0;

    // reset holds for four edges whatever the other inputs do
    chk.open_test("reset");
    repeat (4) begin
      drive(coin(), coin(), coin(), coin(), coin(), out_sel_t'($urandom),
            oper_t'($urandom), oper_t'($urandom));
    end
    clk_en      <= 1'b0;
    acc_ff_rstn <= 1'b1;
    repeat (4) begin
      drive(1'b0, coin(), coin(), coin(), coin(), out_sel_t'($urandom),
            oper_t'($urandom), oper_t'($urandom));
    end
    end_phase();

    chk.open_test("unsigned_acc");
    repeat (300) begin
      drive(coin(), 1'b0, 1'b0, 1'b0, 1'b0, out_sel_t'($urandom),
            oper_t'($urandom), oper_t'($urandom));
    end
    end_phase();

    chk.open_test("twos_comp_acc");
    drive(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, '0, signed_oper(), signed_oper());
    repeat (300) begin
      drive(coin(), 1'b0, 1'b0, 1'b0, 1'b1, out_sel_t'($urandom),
            signed_oper(), signed_oper());
    end
    end_phase();

    // clear and round overlap now and then
    chk.open_test("clear_round");
    repeat (300) begin
      drive(($urandom % 4) != 0, ($urandom % 5) == 0, ($urandom % 3) == 0, 1'b0, coin(),
            out_sel_t'($urandom), oper_t'($urandom), oper_t'($urandom));
    end
    end_phase();

    // unsigned clamp, then signed clamp at the positive and the negative limit
    chk.open_test("saturation");
    fill_small(1'b0);
    push_until_sat(1'b0, 1'b0);
    fill_small(1'b1);
    push_until_sat(1'b1, 1'b0);
    fill_small(1'b1);
    push_until_sat(1'b1, 1'b1);
    end_phase();

    // the accumulator holds while tc and acc_sat flip at the output
    if (!timed_out) begin
      chk.open_test("output_mode");
      drive(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, '0, {2'b10, 30'($urandom)}, {2'b01, 30'($urandom)});
      repeat (40) begin
        drive(1'b0, coin(), coin(), coin(), coin(), sat_sel(),
              oper_t'($urandom), oper_t'($urandom));
      end
      drive(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, '0, {2'b01, 30'($urandom)}, {2'b01, 30'($urandom)});
      repeat (40) begin
        drive(1'b0, coin(), coin(), coin(), coin(), sat_sel(),
              oper_t'($urandom), oper_t'($urandom));
      end
      end_phase();
    end

    chk.print_counts();
    if (err_total == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+design
design/mac_arith_pkg.sv
design/mac_ctrl_pkg.sv
design/mac_unit.sv
design/acc_out_stage.sv
design/mac_32bit.sv
verif/mac_checker.sv
verif/tb_mac_32bit.sv

// File: Makefile
# Verilator build and run of the 32-bit MAC testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_mac_32bit
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary -j $(JOBS)

# sources come from the file list, the header sits in the include directory
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := design/mac_settings.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, the header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

# pass or fail is decided by the log, not by the exit code of the binary
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
